//--- src/tlb_cfg.svh
/*
 * Size settings for the 32-entry TLB. Included by the package and by
 * every module that needs entry counts or address widths.
 */
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

`define TLB_ENTRIES     32
`define TLB_INDEX_BITS  5
`define TLB_ADDR_BITS   32
`define TLB_OFFSET_BITS 12
`define TLB_PAGE_BITS   20
`define TLB_TREE_NODES  31

`endif

//--- src/tlb_pkg.sv
/*
 * Shared types for the TLB. The linear address is read either as one
 * flat word or as a page number over a page offset.
 */
`include "tlb_cfg.svh"

package tlb_pkg;

    // Page number and offset view of an address
    typedef struct packed {
        logic [`TLB_PAGE_BITS-1:0]   page;
        logic [`TLB_OFFSET_BITS-1:0] offset;
    } tlb_addr_split_t;

    // Flat word for pass-through, split view for match and hit
    typedef union packed {
        logic [`TLB_ADDR_BITS-1:0] word;
        tlb_addr_split_t           split;
    } tlb_addr_u;

endpackage

//--- src/tlb_match.sv
/*
 * Input side of the TLB. Compares the translate page and the flush page
 * against all stored pages in parallel, one hit bit per entry.
 */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_match (
    input  logic                                      translate_do,
    input  tlb_pkg::tlb_addr_u                        translate_linear,
    input  logic                                      flush_single_do,
    input  tlb_pkg::tlb_addr_u                        flush_single_address,
    input  logic [`TLB_ENTRIES-1:0]                   entry_valid,
    input  logic [`TLB_ENTRIES-1:0][`TLB_PAGE_BITS-1:0] entry_page,
    output logic [`TLB_ENTRIES-1:0]                   translate_hit,
    output logic [`TLB_ENTRIES-1:0]                   flush_hit
);

    import tlb_pkg::*;

    // ------------------------------------------------------------------
    // Parallel compare qualified by valid and the request strobes
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            translate_hit[i] = translate_do && entry_valid[i] &&
                               (entry_page[i] == translate_linear.split.page);
            // Only live entries get dropped by a page flush
            flush_hit[i]     = flush_single_do && entry_valid[i] &&
                               (entry_page[i] == flush_single_address.split.page);
        end
    end

endmodule

//--- src/tlb_entries.sv
/*
 * Entry storage of the TLB. Chooses the fill slot, applies the flushes
 * and the clean-write invalidation, and reports one touch per cycle to
 * the replacement tree.
 */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_entries (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        rw,
    input  logic                                        fill_do,
    input  logic [`TLB_ADDR_BITS-1:0]                   fill_linear,
    input  logic [`TLB_ADDR_BITS-1:0]                   fill_physical,
    input  logic                                        fill_combined_rw,
    input  logic                                        fill_combined_su,
    input  logic                                        flush_all_do,
    input  logic [`TLB_ENTRIES-1:0]                     flush_hit,
    input  logic [`TLB_ENTRIES-1:0]                     translate_hit,
    input  logic                                        clean_write,
    input  logic [`TLB_INDEX_BITS-1:0]                  victim_index,
    output logic [`TLB_ENTRIES-1:0]                     entry_valid,
    output logic [`TLB_ENTRIES-1:0][`TLB_PAGE_BITS-1:0] entry_page,
    output logic [`TLB_ENTRIES-1:0][`TLB_PAGE_BITS-1:0] entry_physical,
    output logic [`TLB_ENTRIES-1:0]                     entry_dirty,
    output logic [`TLB_ENTRIES-1:0]                     entry_rw,
    output logic [`TLB_ENTRIES-1:0]                     entry_su,
    output logic                                        touch_do,
    output logic [`TLB_INDEX_BITS-1:0]                  touch_index
);

    logic [`TLB_INDEX_BITS-1:0] free_index;
    logic [`TLB_INDEX_BITS-1:0] fill_index;
    logic [`TLB_INDEX_BITS-1:0] hit_index;
    logic [`TLB_ENTRIES-1:0]    fill_sel;
    logic [`TLB_ENTRIES-1:0]    drop_sel;
    logic                       full;

    // ------------------------------------------------------------------
    // Slot choice
    // ------------------------------------------------------------------

    // Downward scan so the lowest index wins
    always_comb begin
        free_index = '0;
        hit_index  = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_index = i[`TLB_INDEX_BITS-1:0];
            end
            if (translate_hit[i]) begin
                hit_index = i[`TLB_INDEX_BITS-1:0];
            end
        end
    end

    assign full       = &entry_valid;
    assign fill_index = full ? victim_index : free_index;

    always_comb begin
        fill_sel = '0;
        fill_sel[fill_index] = fill_do;
        // Page flush plus the clean entry hit by a write
        drop_sel = flush_hit;
        drop_sel[hit_index] = drop_sel[hit_index] | clean_write;
    end

    // Fill slot takes precedence over the hit entry
    assign touch_do    = fill_do || (|translate_hit);
    assign touch_index = fill_do ? fill_index : hit_index;

    // ------------------------------------------------------------------
    // State update
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (flush_all_do) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= (entry_valid | fill_sel) & ~drop_sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (fill_sel[i]) begin
                entry_page[i]     <= fill_linear[`TLB_ADDR_BITS-1:`TLB_OFFSET_BITS];
                entry_physical[i] <= fill_physical[`TLB_ADDR_BITS-1:`TLB_OFFSET_BITS];
                entry_rw[i]       <= fill_combined_rw;
                entry_su[i]       <= fill_combined_su;
                entry_dirty[i]    <= rw;
            end
        end
    end

endmodule

//--- src/tlb_plru.sv
/*
 * Tree pseudo-LRU for the 32 TLB entries. Walks the 31-node tree for the
 * victim and points each node on a touched path away from that entry.
 */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_plru (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush_all_do,
    input  logic                       touch_do,
    input  logic [`TLB_INDEX_BITS-1:0] touch_index,
    output logic [`TLB_INDEX_BITS-1:0] victim_index
);

    logic [`TLB_TREE_NODES-1:0] tree;
    logic [`TLB_TREE_NODES-1:0] tree_next;

    // Node on the path at a level, given the upper index bits
    function automatic logic [`TLB_INDEX_BITS-1:0] node_of(
        input int                         level,
        input logic [`TLB_INDEX_BITS-1:0] index
    );
        int n;
        n = (1 << level) - 1 + int'(index >> (`TLB_INDEX_BITS - level));
        return n[`TLB_INDEX_BITS-1:0];
    endfunction

    // ------------------------------------------------------------------
    // Victim walk where 0 goes left and 1 goes right
    // ------------------------------------------------------------------
    always_comb begin
        logic [`TLB_INDEX_BITS-1:0] path;
        path = '0;
        for (int l = 0; l < `TLB_INDEX_BITS; l++) begin
            path[`TLB_INDEX_BITS-1-l] = tree[node_of(l, path)];
        end
        victim_index = path;
    end

    // ------------------------------------------------------------------
    // Touch update
    // ------------------------------------------------------------------
    always_comb begin
        tree_next = tree;
        for (int l = 0; l < `TLB_INDEX_BITS; l++) begin
            // Left subtree entry sets the node to 1
            tree_next[node_of(l, touch_index)] = ~touch_index[`TLB_INDEX_BITS-1-l];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tree <= '0;
        end else if (flush_all_do) begin
            tree <= '0;
        end else if (touch_do) begin
            tree <= tree_next;
        end
    end

endmodule

//--- src/tlb_result.sv
/*
 * Output side of the TLB. Picks the lowest hit entry, applies the dirty
 * rule and forms the physical address or the pass-through word.
 */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_result (
    input  tlb_pkg::tlb_addr_u                          translate_linear,
    input  logic                                        rw,
    input  logic [`TLB_ENTRIES-1:0]                     translate_hit,
    input  logic [`TLB_ENTRIES-1:0][`TLB_PAGE_BITS-1:0] entry_physical,
    input  logic [`TLB_ENTRIES-1:0]                     entry_dirty,
    input  logic [`TLB_ENTRIES-1:0]                     entry_rw,
    input  logic [`TLB_ENTRIES-1:0]                     entry_su,
    output logic                                        translate_valid,
    output logic [`TLB_ADDR_BITS-1:0]                   translate_physical,
    output logic                                        translate_combined_rw,
    output logic                                        translate_combined_su,
    output logic                                        clean_write
);

    import tlb_pkg::*;

    logic                      sel_any;
    logic [`TLB_PAGE_BITS-1:0] sel_physical;
    logic                      sel_dirty;
    tlb_addr_u                 hit_addr;

    // Lowest hit entry wins
    always_comb begin
        sel_any               = 1'b0;
        sel_physical          = '0;
        sel_dirty             = 1'b0;
        translate_combined_rw = 1'b0;
        translate_combined_su = 1'b0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (translate_hit[i]) begin
                sel_any               = 1'b1;
                sel_physical          = entry_physical[i];
                sel_dirty             = entry_dirty[i];
                translate_combined_rw = entry_rw[i];
                translate_combined_su = entry_su[i];
            end
        end
    end

    always_comb begin
        hit_addr.split.page   = sel_physical;
        hit_addr.split.offset = translate_linear.split.offset;
    end

    // A write needs the dirty bit already set
    assign translate_valid    = sel_any && (!rw || sel_dirty);
    assign clean_write        = sel_any && rw && !sel_dirty;
    assign translate_physical = translate_valid ? hit_addr.word : translate_linear.word;

endmodule

//--- src/tlb_top.sv
/*
 * Top level of the 32-entry fully associative TLB. Connects tag match,
 * entry storage, the replacement tree and result formation.
 */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      translate_do,
    input  logic [`TLB_ADDR_BITS-1:0] translate_linear,
    input  logic                      rw,
    input  logic                      fill_do,
    input  logic [`TLB_ADDR_BITS-1:0] fill_linear,
    input  logic [`TLB_ADDR_BITS-1:0] fill_physical,
    input  logic                      fill_combined_rw,
    input  logic                      fill_combined_su,
    input  logic                      flush_single_do,
    input  logic [`TLB_ADDR_BITS-1:0] flush_single_address,
    input  logic                      flush_all_do,
    output logic                      translate_valid,
    output logic [`TLB_ADDR_BITS-1:0] translate_physical,
    output logic                      translate_combined_rw,
    output logic                      translate_combined_su
);

    import tlb_pkg::*;

    tlb_addr_u                                   translate_addr;
    tlb_addr_u                                   flush_addr;
    logic [`TLB_ENTRIES-1:0]                     entry_valid;
    logic [`TLB_ENTRIES-1:0][`TLB_PAGE_BITS-1:0] entry_page;
    logic [`TLB_ENTRIES-1:0][`TLB_PAGE_BITS-1:0] entry_physical;
    logic [`TLB_ENTRIES-1:0]                     entry_dirty;
    logic [`TLB_ENTRIES-1:0]                     entry_rw;
    logic [`TLB_ENTRIES-1:0]                     entry_su;
    logic [`TLB_ENTRIES-1:0]                     translate_hit;
    logic [`TLB_ENTRIES-1:0]                     flush_hit;
    logic                                        clean_write;
    logic                                        touch_do;
    logic [`TLB_INDEX_BITS-1:0]                  touch_index;
    logic [`TLB_INDEX_BITS-1:0]                  victim_index;

    assign translate_addr.word = translate_linear;
    assign flush_addr.word     = flush_single_address;

    tlb_match u_match (
        .translate_do         (translate_do),
        .translate_linear     (translate_addr),
        .flush_single_do      (flush_single_do),
        .flush_single_address (flush_addr),
        .entry_valid          (entry_valid),
        .entry_page           (entry_page),
        .translate_hit        (translate_hit),
        .flush_hit            (flush_hit)
    );

    tlb_entries u_entries (
        .clk              (clk),
        .rst_n            (rst_n),
        .rw               (rw),
        .fill_do          (fill_do),
        .fill_linear      (fill_linear),
        .fill_physical    (fill_physical),
        .fill_combined_rw (fill_combined_rw),
        .fill_combined_su (fill_combined_su),
        .flush_all_do     (flush_all_do),
        .flush_hit        (flush_hit),
        .translate_hit    (translate_hit),
        .clean_write      (clean_write),
        .victim_index     (victim_index),
        .entry_valid      (entry_valid),
        .entry_page       (entry_page),
        .entry_physical   (entry_physical),
        .entry_dirty      (entry_dirty),
        .entry_rw         (entry_rw),
        .entry_su         (entry_su),
        .touch_do         (touch_do),
        .touch_index      (touch_index)
    );

    tlb_plru u_plru (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_all_do (flush_all_do),
        .touch_do     (touch_do),
        .touch_index  (touch_index),
        .victim_index (victim_index)
    );

    tlb_result u_result (
        .translate_linear      (translate_addr),
        .rw                    (rw),
        .translate_hit         (translate_hit),
        .entry_physical        (entry_physical),
        .entry_dirty           (entry_dirty),
        .entry_rw              (entry_rw),
        .entry_su              (entry_su),
        .translate_valid       (translate_valid),
        .translate_physical    (translate_physical),
        .translate_combined_rw (translate_combined_rw),
        .translate_combined_su (translate_combined_su),
        .clean_write           (clean_write)
    );

endmodule

//--- test/tlb_tb.sv
/*
 * Testbench for the TLB. Builds a table of commands and expected results,
 * then applies it one row per clock, driving on the falling edge.
 */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_tb;

    localparam int OP_TRANSLATE = 0;
    localparam int OP_FILL      = 1;
    localparam int OP_FLUSH     = 2;
    localparam int OP_FLUSH_ALL = 3;

    typedef struct {
        int          test;
        int          op;
        logic        rw;
        logic [31:0] addr;
        logic [31:0] phys;
        logic        attr_rw;
        logic        attr_su;
        logic        exp_valid;
        logic [31:0] exp_phys;
        logic        exp_rw;
        logic        exp_su;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        translate_do;
    logic [31:0] translate_linear;
    logic        rw;
    logic        fill_do;
    logic [31:0] fill_linear;
    logic [31:0] fill_physical;
    logic        fill_combined_rw;
    logic        fill_combined_su;
    logic        flush_single_do;
    logic [31:0] flush_single_address;
    logic        flush_all_do;
    logic        translate_valid;
    logic [31:0] translate_physical;
    logic        translate_combined_rw;
    logic        translate_combined_su;

    row_t        rows [$];
    bit   [30:0] model_tree;
    int          fall_count;
    int          errors;
    int          checks;
    int          test_errors [1:6];
    string       test_names [1:6];
    bit          timed_out;

    tlb_top uut (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .translate_do          (translate_do),
        .translate_linear      (translate_linear),
        .rw                    (rw),
        .fill_do               (fill_do),
        .fill_linear           (fill_linear),
        .fill_physical         (fill_physical),
        .fill_combined_rw      (fill_combined_rw),
        .fill_combined_su      (fill_combined_su),
        .flush_single_do       (flush_single_do),
        .flush_single_address  (flush_single_address),
        .flush_all_do          (flush_all_do),
        .translate_valid       (translate_valid),
        .translate_physical    (translate_physical),
        .translate_combined_rw (translate_combined_rw),
        .translate_combined_su (translate_combined_su)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        fall_count <= fall_count + 1;
    end

    // ------------------------------------------------------------------
    // Table rows
    // ------------------------------------------------------------------
    function automatic void append_row(
        input int          test,
        input int          op,
        input logic        rw_bit,
        input logic [31:0] addr,
        input logic [31:0] phys,
        input logic        a_rw,
        input logic        a_su,
        input logic        exp_valid,
        input logic [31:0] exp_phys
    );
        row_t r;
        r.test      = test;
        r.op        = op;
        r.rw        = rw_bit;
        r.addr      = addr;
        r.phys      = phys;
        r.attr_rw   = a_rw;
        r.attr_su   = a_su;
        r.exp_valid = exp_valid;
        r.exp_phys  = exp_phys;
        r.exp_rw    = a_rw;
        r.exp_su    = a_su;
        rows.push_back(r);
    endfunction

    // A miss passes the linear word straight through
    function automatic void expect_miss(input int test, input logic rw_bit,
                                        input logic [31:0] addr);
        append_row(test, OP_TRANSLATE, rw_bit, addr, '0, 1'b0, 1'b0, 1'b0, addr);
    endfunction

    // Physical page of the fill over the offset of the request
    function automatic void expect_hit(input int test, input logic rw_bit,
                                       input logic [31:0] addr, input logic [31:0] phys,
                                       input logic a_rw, input logic a_su);
        append_row(test, OP_TRANSLATE, rw_bit, addr, phys, a_rw, a_su, 1'b1,
                   {phys[31:12], addr[11:0]});
    endfunction

    function automatic void fill_page(input int test, input logic rw_bit,
                                      input logic [31:0] lin, input logic [31:0] phys,
                                      input logic a_rw, input logic a_su);
        append_row(test, OP_FILL, rw_bit, lin, phys, a_rw, a_su, 1'b0, '0);
    endfunction

    function automatic void flush_page(input int test, input logic [31:0] addr);
        append_row(test, OP_FLUSH, 1'b0, addr, '0, 1'b0, 1'b0, 1'b0, '0);
    endfunction

    function automatic void clear_all(input int test);
        append_row(test, OP_FLUSH_ALL, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, '0);
    endfunction

    // ------------------------------------------------------------------
    // Replacement model with node n over children 2n+1 and 2n+2
    // ------------------------------------------------------------------
    function automatic void touch_model(input int entry);
        int node;
        int base;
        int size;
        node = 0;
        base = 0;
        size = `TLB_ENTRIES;
        for (int l = 0; l < 5; l++) begin
            size = size / 2;
            if (entry < base + size) begin
                model_tree[node] = 1'b1;
                node = 2 * node + 1;
            end else begin
                model_tree[node] = 1'b0;
                base = base + size;
                node = 2 * node + 2;
            end
        end
    endfunction

    function automatic int pick_victim();
        int node;
        int base;
        int size;
        node = 0;
        base = 0;
        size = `TLB_ENTRIES;
        for (int l = 0; l < 5; l++) begin
            size = size / 2;
            if (model_tree[node]) begin
                base = base + size;
                node = 2 * node + 2;
            end else begin
                node = 2 * node + 1;
            end
        end
        return base;
    endfunction

    function automatic void build_table();
        logic [19:0] pg [0:32];
        logic [19:0] pp [0:32];
        logic        ar [0:32];
        logic        as [0:32];
        int          owner [0:31];
        logic [31:0] word;
        bit          dup;
        int          k;
        int          v;
        expect_miss(1, 1'b0, 32'h0000_0000);
        expect_miss(1, 1'b0, 32'h1234_5678);
        expect_miss(1, 1'b1, 32'hFFFF_FFFF);
        fill_page(2, 1'b0, 32'h0040_0000, 32'h8765_4000, 1'b1, 1'b0);
        expect_hit(2, 1'b0, 32'h0040_0123, 32'h8765_4000, 1'b1, 1'b0);
        expect_hit(2, 1'b0, 32'h0040_0FFF, 32'h8765_4000, 1'b1, 1'b0);
        fill_page(2, 1'b1, 32'h0A0B_C000, 32'h1111_1000, 1'b0, 1'b1);
        expect_hit(2, 1'b0, 32'h0A0B_C004, 32'h1111_1000, 1'b0, 1'b1);
        // Clean page written, then gone
        expect_miss(3, 1'b1, 32'h0040_0010);
        expect_miss(3, 1'b0, 32'h0040_0010);
        expect_hit(3, 1'b1, 32'h0A0B_C555, 32'h1111_1000, 1'b0, 1'b1);
        fill_page(4, 1'b0, 32'h0050_0000, 32'h2222_2000, 1'b0, 1'b0);
        expect_hit(4, 1'b0, 32'h0050_0100, 32'h2222_2000, 1'b0, 1'b0);
        flush_page(4, 32'h0050_0ABC);
        expect_miss(4, 1'b0, 32'h0050_0100);
        expect_hit(4, 1'b0, 32'h0A0B_C010, 32'h1111_1000, 1'b0, 1'b1);
        fill_page(5, 1'b1, 32'h0060_0000, 32'h3333_3000, 1'b1, 1'b1);
        expect_hit(5, 1'b0, 32'h0060_0001, 32'h3333_3000, 1'b1, 1'b1);
        clear_all(5);
        expect_miss(5, 1'b0, 32'h0060_0001);
        expect_miss(5, 1'b0, 32'h0A0B_C010);
        expect_miss(5, 1'b1, 32'h0060_0002);

        // Replacement over distinct random pages
        clear_all(6);
        model_tree = '0;
        for (int i = 0; i <= 32; i++) begin
            dup = 1'b1;
            while (dup) begin
                word  = $urandom();
                pg[i] = word[31:12];
                dup   = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (pg[j] == pg[i]) begin
                        dup = 1'b1;
                    end
                end
            end
            word  = $urandom();
            pp[i] = word[19:0];
            ar[i] = word[20];
            as[i] = word[21];
        end
        // Empty TLB takes fills in index order
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            fill_page(6, 1'b0, {pg[i], 12'h000}, {pp[i], 12'h000}, ar[i], as[i]);
            touch_model(i);
            owner[i] = i;
        end
        for (int i = 0; i < `TLB_ENTRIES + 8; i++) begin
            k = (i < `TLB_ENTRIES) ? i : int'($urandom() % `TLB_ENTRIES);
            word = $urandom();
            expect_hit(6, 1'b0, {pg[k], word[11:0]}, {pp[k], 12'h000}, ar[k], as[k]);
            touch_model(k);
        end
        v = pick_victim();
        fill_page(6, 1'b0, {pg[32], 12'h000}, {pp[32], 12'h000}, ar[32], as[32]);
        touch_model(v);
        owner[v] = 32;
        expect_miss(6, 1'b0, {pg[v], 12'h7A4});
        for (int e = 0; e < `TLB_ENTRIES; e++) begin
            k = owner[e];
            expect_hit(6, 1'b0, {pg[k], 12'h3C8}, {pp[k], 12'h000}, ar[k], as[k]);
            touch_model(e);
        end
    endfunction

    // ------------------------------------------------------------------
    // Drive and wait
    // ------------------------------------------------------------------
    task automatic next_fall(output bit ok);
        int start;
        int spins;
        start = fall_count;
        spins = 0;
        while (fall_count == start && spins < 40) begin
            #1;
            spins++;
        end
        ok = (fall_count != start);
    endtask

    task automatic drive_row(input row_t r);
        translate_do         = (r.op == OP_TRANSLATE);
        translate_linear     = r.addr;
        rw                   = r.rw;
        fill_do              = (r.op == OP_FILL);
        fill_linear          = r.addr;
        fill_physical        = r.phys;
        fill_combined_rw     = r.attr_rw;
        fill_combined_su     = r.attr_su;
        flush_single_do      = (r.op == OP_FLUSH);
        flush_single_address = r.addr;
        flush_all_do         = (r.op == OP_FLUSH_ALL);
    endtask

    initial begin
        bit ok;
        int t;
        rst_n                = 1'b0;
        translate_do         = 1'b0;
        translate_linear     = '0;
        rw                   = 1'b0;
        fill_do              = 1'b0;
        fill_linear          = '0;
        fill_physical        = '0;
        fill_combined_rw     = 1'b0;
        fill_combined_su     = 1'b0;
        flush_single_do      = 1'b0;
        flush_single_address = '0;
        flush_all_do         = 1'b0;
        test_names[1] = "empty after reset";
        test_names[2] = "fill then read";
        test_names[3] = "dirty rule";
        test_names[4] = "flush single";
        test_names[5] = "flush all";
        test_names[6] = "replacement";
        void'($urandom(32'hb6bd8b37));
        build_table();

        // Half-step offset keeps polling off the clock edges
        #0.5;
        for (int c = 0; c < 2 && !timed_out; c++) begin
            next_fall(ok);
            timed_out = !ok;
        end
        rst_n = 1'b1;

        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            next_fall(ok);
            timed_out = !ok;
            if (ok) begin
                drive_row(rows[i]);
                #2;
                t = rows[i].test;
                if (rows[i].op == OP_TRANSLATE) begin
                    checks++;
                    if (translate_valid !== rows[i].exp_valid) begin
                        $display("FAILED at %0t: row %0d addr %h valid %b, expected %b",
                                 $realtime, i, rows[i].addr, translate_valid,
                                 rows[i].exp_valid);
                        test_errors[t]++;
                    end
                    if (translate_physical !== rows[i].exp_phys) begin
                        $display("FAILED at %0t: row %0d addr %h physical %h, expected %h",
                                 $realtime, i, rows[i].addr, translate_physical,
                                 rows[i].exp_phys);
                        test_errors[t]++;
                    end
                    if (rows[i].exp_valid && translate_combined_rw !== rows[i].exp_rw) begin
                        $display("FAILED at %0t: row %0d addr %h rw %b, expected %b",
                                 $realtime, i, rows[i].addr, translate_combined_rw,
                                 rows[i].exp_rw);
                        test_errors[t]++;
                    end
                    if (rows[i].exp_valid && translate_combined_su !== rows[i].exp_su) begin
                        $display("FAILED at %0t: row %0d addr %h su %b, expected %b",
                                 $realtime, i, rows[i].addr, translate_combined_su,
                                 rows[i].exp_su);
                        test_errors[t]++;
                    end
                end
                if (i == rows.size() - 1 || rows[i + 1].test != t) begin
                    $display("test %0d %s: %0d errors", t, test_names[t], test_errors[t]);
                    errors += test_errors[t];
                end
            end
        end

        if (timed_out) begin
            $display("Clock stopped: no falling edge seen within the wait limit");
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
src/tlb_pkg.sv
src/tlb_match.sv
src/tlb_entries.sv
src/tlb_plru.sv
src/tlb_result.sv
src/tlb_top.sv
test/tlb_tb.sv

//--- run.sh
#!/bin/sh
# Builds the TLB testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f compile.f --top-module tlb_tb -o tlb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tlb_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
